/* all.f */
design/mitm_pkg.sv
design/spi_bus_pkg.sv
design/bus_sampler.sv
design/chunk_counter.sv
design/mode_button.sv
design/bus_splice.sv
design/mitm_ctrl.sv
design/mitm_top.sv
dv/mitm_asserts.sv
dv/tb_mitm_top.sv

/* design/bus_sampler.sv */
`timescale 1ns/1ps

// brings the four spi lines into sys_clk
// two sync flops each, one more on sclk and ss for edges
module bus_sampler (
	input  logic sys_clk,
	input  logic arst_n,

	// raw pins
	input  logic miso_in,
	input  logic mosi_in,
	input  logic sclk_in,
	input  logic ss_in,

	// synchronised lines, 2 cycles behind the pins
	output logic sync_miso,
	output logic sync_mosi,
	output logic sync_sclk,
	output logic sync_ss,

	// single cycle edge pulses
	output logic sclk_rise,
	output logic sclk_fall,
	output logic ss_fall,
	output logic ss_rise
);

	logic [1:0] miso_ff;	// [0] is the metastable stage
	logic [1:0] mosi_ff;
	logic [2:0] sclk_ff;	// [2] is the edge detect stage
	logic [2:0] ss_ff;

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			miso_ff <= '0;
			mosi_ff <= '0;
			sclk_ff <= '0;	// mode 0 idles low
			ss_ff   <= '1;	// no slave selected
		end else begin
			miso_ff <= {miso_ff[0], miso_in};
			mosi_ff <= {mosi_ff[0], mosi_in};
			sclk_ff <= {sclk_ff[1:0], sclk_in};
			ss_ff   <= {ss_ff[1:0], ss_in};
		end
	end

	assign sync_miso = miso_ff[1];
	assign sync_mosi = mosi_ff[1];
	assign sync_sclk = sclk_ff[1];
	assign sync_ss   = ss_ff[1];

	assign sclk_rise = sclk_ff[1] & ~sclk_ff[2];	// sampling edge
	assign sclk_fall = ~sclk_ff[1] & sclk_ff[2];	// shift edge
	assign ss_fall   = ~ss_ff[1] & ss_ff[2];	// transaction start
	assign ss_rise   = ss_ff[1] & ~ss_ff[2];	// transaction end

endmodule : bus_sampler

/* design/bus_splice.sv */
`timescale 1ns/1ps

// data path of the mitm
// captures the real chunks and drives the four output lines
// a faked line takes FAKE_WORD bits on the shift edge instead of the real line
module bus_splice import spi_bus_pkg::*; #(
	parameter logic [CHUNK_BITS-1:0] FAKE_WORD = 9'h1A5
) (
	input  logic                     sys_clk,
	input  logic                     arst_n,

	input  logic                     sync_miso,
	input  logic                     sync_mosi,
	input  logic                     sync_sclk,
	input  logic                     sync_ss,
	input  logic                     sclk_rise,
	input  logic                     sclk_fall,
	input  logic                     ss_fall,

	input  logic                     chunk_done,
	input  logic [BIT_IDX_WIDTH-1:0] bit_idx,
	input  logic                     fake_mosi_sel,	// from the fsm
	input  logic                     fake_miso_sel,

	output spi_chunk_u               real_mosi_word,	// valid while chunk_done is high
	output spi_chunk_u               real_miso_word,

	output logic                     miso_out,
	output logic                     mosi_out,
	output logic                     sclk_out,
	output logic                     ss_out
);

	localparam logic [BIT_IDX_WIDTH-1:0] LAST_IDX = BIT_IDX_WIDTH'(CHUNK_BITS - 1);

	logic [CHUNK_BITS-2:0]    mosi_shift;	// first 8 bits of the chunk
	logic [CHUNK_BITS-2:0]    miso_shift;
	logic [BIT_IDX_WIDTH-1:0] fake_idx;
	logic                     fake_bit;
	logic                     fake_load;

	// msb leaves first
	// bit_idx is 0 at ss fall so bit 8 goes out before the first rise
	assign fake_idx  = LAST_IDX - bit_idx;
	assign fake_bit  = FAKE_WORD[fake_idx];
	assign fake_load = sclk_fall | ss_fall;

	// 9th bit comes straight from the line in the chunk_done cycle
	assign real_mosi_word.raw = {mosi_shift, sync_mosi};
	assign real_miso_word.raw = {miso_shift, sync_miso};

	always_ff @(posedge sys_clk) begin
		if (ss_fall || chunk_done) begin
			mosi_shift <= '0;	// next chunk starts empty
			miso_shift <= '0;
		end else if (sclk_rise) begin
			mosi_shift <= {mosi_shift[CHUNK_BITS-3:0], sync_mosi};
			miso_shift <= {miso_shift[CHUNK_BITS-3:0], sync_miso};
		end
	end

	// output stage adds the third cycle of latency on every line
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			sclk_out <= 1'b0;
			ss_out   <= 1'b1;	// bus idle
			mosi_out <= 1'b0;
			miso_out <= 1'b0;
		end else begin
			sclk_out <= sync_sclk;
			ss_out   <= sync_ss;

			if (!fake_mosi_sel) begin
				mosi_out <= sync_mosi;
			end else if (fake_load) begin
				mosi_out <= fake_bit;	// held until the next shift edge
			end

			if (!fake_miso_sel) begin
				miso_out <= sync_miso;
			end else if (fake_load) begin
				miso_out <= fake_bit;
			end
		end
	end

endmodule : bus_splice

/* design/chunk_counter.sv */
`timescale 1ns/1ps

// bit position inside the current chunk
// paces both the control fsm and the splice
module chunk_counter import spi_bus_pkg::*; (
	input  logic                     sys_clk,
	input  logic                     arst_n,
	input  logic                     sclk_rise,
	input  logic                     ss_fall,
	input  logic                     ss_rise,
	output logic [BIT_IDX_WIDTH-1:0] bit_idx,	// rises seen so far in this chunk
	output logic                     chunk_done	// 9th rise of a chunk
);

	localparam logic [BIT_IDX_WIDTH-1:0] LAST_IDX = BIT_IDX_WIDTH'(CHUNK_BITS - 1);

	logic in_txn;	// ss currently low

	// stray sclk edges with ss high are not counted
	assign chunk_done = in_txn & sclk_rise & (bit_idx == LAST_IDX);

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			bit_idx <= '0;
			in_txn  <= 1'b0;
		end else if (ss_fall || ss_rise) begin
			bit_idx <= '0;	// both ends of a transaction start clean
			in_txn  <= ss_fall;
		end else if (in_txn && sclk_rise) begin
			if (chunk_done) begin
				bit_idx <= '0;	// wrap, next chunk starts at 0
			end else begin
				bit_idx <= bit_idx + 1'b1;
			end
		end
	end

endmodule : chunk_counter

/* design/mitm_ctrl.sv */
`timescale 1ns/1ps

// transaction fsm
// decodes the command chunk and picks the data chunks to fake
module mitm_ctrl import mitm_pkg::*, spi_bus_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  arst_n,
	input  logic [MODE_WIDTH-1:0] mode,	// live button mode
	input  logic                  ss_fall,
	input  logic                  ss_rise,
	input  logic                  chunk_done,
	input  spi_chunk_u            real_mosi_word,
	output logic                  fake_mosi_sel,	// upcoming chunk on mosi is faked
	output logic                  fake_miso_sel,
	output logic                  comm_active
);

	localparam logic [1:0] IDLE = 2'd0;	// ss high
	localparam logic [1:0] CMD  = 2'd1;	// first chunk in flight
	localparam logic [1:0] DATA = 2'd2;	// data chunks

	logic [1:0]            state;
	logic [MODE_WIDTH-1:0] mode_q;	// frozen at ss fall
	logic                  rw_q;	// 1 = write and mosi attacked
	logic                  odd_q;	// index parity of the current data chunk
	logic                  next_odd;
	logic                  next_rw;
	logic                  next_fake;

	// does the mode fake a data chunk with this parity
	function automatic logic chunk_faked(input logic [MODE_WIDTH-1:0] m, input logic odd);
		case (m)
			MODE_SUB_ALL:  return 1'b1;
			MODE_SUB_HALF: return odd;	// chunks 1, 3, 5 ...
			default:       return 1'b0;	// forward
		endcase
	endfunction

	// the chunk after the command is data index 0
	assign next_odd  = (state == CMD) ? 1'b0 : ~odd_q;
	assign next_rw   = (state == CMD) ? real_mosi_word.cmd.rw : rw_q;
	assign next_fake = chunk_faked(mode_q, next_odd);

	assign comm_active = (state != IDLE);

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			state         <= IDLE;
			mode_q        <= MODE_FORWARD;
			rw_q          <= 1'b0;
			odd_q         <= 1'b0;
			fake_mosi_sel <= 1'b0;
			fake_miso_sel <= 1'b0;
		end else if (ss_rise) begin
			state         <= IDLE;	// transaction over so both lines released
			fake_mosi_sel <= 1'b0;
			fake_miso_sel <= 1'b0;
		end else if (ss_fall) begin
			state         <= CMD;
			mode_q        <= mode;	// mode changes wait for the next transaction
			fake_mosi_sel <= 1'b0;	// command always passes
			fake_miso_sel <= 1'b0;
		end else if (chunk_done && state != IDLE) begin
			state         <= DATA;
			rw_q          <= next_rw;
			odd_q         <= next_odd;
			fake_mosi_sel <= next_fake & next_rw;
			fake_miso_sel <= next_fake & ~next_rw;	// read fakes the slave reply
		end
	end

endmodule : mitm_ctrl

/* design/mitm_pkg.sv */
// attack modes for the mitm core
// one-hot, rotated left by the mode button
package mitm_pkg;

	// one-hot mode word
	localparam int MODE_WIDTH = 3;

	// chunks pass through untouched
	localparam logic [MODE_WIDTH-1:0] MODE_FORWARD = 3'b001;

	// every data chunk in the attacked direction replaced
	localparam logic [MODE_WIDTH-1:0] MODE_SUB_ALL = 3'b010;

	// only odd data chunks replaced
	localparam logic [MODE_WIDTH-1:0] MODE_SUB_HALF = 3'b100;

	// button steps forward -> sub_all -> sub_half -> forward
	// reset value is MODE_FORWARD

endpackage : mitm_pkg

/* design/mitm_top.sv */
`timescale 1ns/1ps

// spi man in the middle between one master and one slave
// pins in, sync, splice, pins out
module mitm_top import mitm_pkg::*, spi_bus_pkg::*; #(
	parameter int                    DEBOUNCE_COUNT = 1_048_576,
	parameter logic [CHUNK_BITS-1:0] FAKE_WORD      = 9'h1A5	// injected chunk
) (
	input  logic                  sys_clk,
	input  logic                  arst_n,

	// user
	input  logic                  mode_btn,	// active low
	output logic [MODE_WIDTH-1:0] mode_leds,
	output logic                  comm_active_led,

	// bus from master and slave
	input  logic                  miso_in,
	input  logic                  mosi_in,
	input  logic                  sclk_in,
	input  logic                  ss_in,

	// bus towards master and slave
	output logic                  miso_out,
	output logic                  mosi_out,
	output logic                  sclk_out,
	output logic                  ss_out
);

	logic                     sync_miso;
	logic                     sync_mosi;
	logic                     sync_sclk;
	logic                     sync_ss;
	logic                     sclk_rise;
	logic                     sclk_fall;
	logic                     ss_fall;
	logic                     ss_rise;

	logic [BIT_IDX_WIDTH-1:0] bit_idx;
	logic                     chunk_done;

	logic [MODE_WIDTH-1:0]    mode;
	logic                     fake_mosi_sel;
	logic                     fake_miso_sel;
	spi_chunk_u               real_mosi_word;

	assign mode_leds = mode;	// leds show the live mode and not the latched one

	bus_sampler sampler_i (
		.sys_clk   (sys_clk),
		.arst_n    (arst_n),
		.miso_in   (miso_in),
		.mosi_in   (mosi_in),
		.sclk_in   (sclk_in),
		.ss_in     (ss_in),
		.sync_miso (sync_miso),
		.sync_mosi (sync_mosi),
		.sync_sclk (sync_sclk),
		.sync_ss   (sync_ss),
		.sclk_rise (sclk_rise),
		.sclk_fall (sclk_fall),
		.ss_fall   (ss_fall),
		.ss_rise   (ss_rise)
	);

	chunk_counter counter_i (
		.sys_clk    (sys_clk),
		.arst_n     (arst_n),
		.sclk_rise  (sclk_rise),
		.ss_fall    (ss_fall),
		.ss_rise    (ss_rise),
		.bit_idx    (bit_idx),
		.chunk_done (chunk_done)
	);

	mode_button #(
		.DEBOUNCE_COUNT (DEBOUNCE_COUNT)
	) button_i (
		.sys_clk  (sys_clk),
		.arst_n   (arst_n),
		.mode_btn (mode_btn),
		.mode     (mode)
	);

	bus_splice #(
		.FAKE_WORD (FAKE_WORD)
	) splice_i (
		.sys_clk        (sys_clk),
		.arst_n         (arst_n),
		.sync_miso      (sync_miso),
		.sync_mosi      (sync_mosi),
		.sync_sclk      (sync_sclk),
		.sync_ss        (sync_ss),
		.sclk_rise      (sclk_rise),
		.sclk_fall      (sclk_fall),
		.ss_fall        (ss_fall),
		.chunk_done     (chunk_done),
		.bit_idx        (bit_idx),
		.fake_mosi_sel  (fake_mosi_sel),
		.fake_miso_sel  (fake_miso_sel),
		.real_mosi_word (real_mosi_word),
		.real_miso_word (),
		.miso_out       (miso_out),
		.mosi_out       (mosi_out),
		.sclk_out       (sclk_out),
		.ss_out         (ss_out)
	);

	mitm_ctrl ctrl_i (
		.sys_clk        (sys_clk),
		.arst_n         (arst_n),
		.mode           (mode),
		.ss_fall        (ss_fall),
		.ss_rise        (ss_rise),
		.chunk_done     (chunk_done),
		.real_mosi_word (real_mosi_word),
		.fake_mosi_sel  (fake_mosi_sel),
		.fake_miso_sel  (fake_miso_sel),
		.comm_active    (comm_active_led)
	);

endmodule : mitm_top

/* design/mode_button.sv */
`timescale 1ns/1ps

// mode select button, active low
// debounced, each accepted press rotates the one-hot mode
module mode_button import mitm_pkg::*; #(
	parameter int DEBOUNCE_COUNT = 1_048_576	// stable cycles before a level is taken
) (
	input  logic                  sys_clk,
	input  logic                  arst_n,
	input  logic                  mode_btn,	// raw pin, low = pressed
	output logic [MODE_WIDTH-1:0] mode
);

	localparam int CNT_W = $clog2(DEBOUNCE_COUNT + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_COUNT - 1);

	logic [1:0]       btn_ff;	// synchroniser
	logic             btn_state;	// debounced level
	logic [CNT_W-1:0] stable_cnt;	// cycles the input has differed from btn_state
	logic             accept;	// input held long enough, take it

	assign accept = (btn_ff[1] != btn_state) && (stable_cnt == CNT_LAST);

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			btn_ff     <= '1;	// released
			btn_state  <= 1'b1;
			stable_cnt <= '0;
		end else begin
			btn_ff <= {btn_ff[0], mode_btn};
			if (btn_ff[1] == btn_state) begin
				stable_cnt <= '0;	// glitch back, start over
			end else if (accept) begin
				btn_state  <= btn_ff[1];
				stable_cnt <= '0;
			end else begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end
	end

	// only a newly accepted low level counts as a press
	// release must be accepted before the next press
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			mode <= MODE_FORWARD;
		end else if (accept && !btn_ff[1]) begin
			mode <= {mode[MODE_WIDTH-2:0], mode[MODE_WIDTH-1]};	// rotate left
		end
	end

endmodule : mode_button

/* design/spi_bus_pkg.sv */
// spi chunk format seen by the mitm
// 9-bit chunks, msb first, mode 0
package spi_bus_pkg;

	localparam int CHUNK_BITS    = 9;	// bits per chunk
	localparam int BIT_IDX_WIDTH = 4;	// holds 0..8
	localparam int ADDR_BITS     = CHUNK_BITS - 1;

	// first chunk of a transaction
	typedef struct packed {
		logic                 rw;		// 1 = write, attack mosi
		logic [ADDR_BITS-1:0] addr;	// register address
	} spi_cmd_t;

	// one captured chunk
	// raw is filled by the shift registers
	// cmd is how the control fsm reads the first chunk
	typedef union packed {
		logic [CHUNK_BITS-1:0] raw;	// shift order, msb first
		spi_cmd_t              cmd;
	} spi_chunk_u;

endpackage : spi_bus_pkg

/* dv/mitm_asserts.sv */
`timescale 1ns/1ps

// pin side checks on the mitm, bound into mitm_top
module mitm_asserts (
	input logic sys_clk,
	input logic arst_n,
	input logic sclk_in,
	input logic ss_in,
	input logic sclk_out,
	input logic ss_out,
	input logic comm_active_led
);

	// 2 sync flops plus the output flop
	ss_delay_a: assert property (@(posedge sys_clk) disable iff (!arst_n)
		ss_out == $past(ss_in, 3))
		else $error("ss_out is not ss_in delayed by 3 cycles");

	sclk_delay_a: assert property (@(posedge sys_clk) disable iff (!arst_n)
		sclk_out == $past(sclk_in, 3))	// same latency keeps the spi phase
		else $error("sclk_out is not sclk_in delayed by 3 cycles");

	// bus idle for a while, fsm must be back in idle
	idle_a: assert property (@(posedge sys_clk) disable iff (!arst_n)
		(ss_out && $past(ss_out) && $past(ss_out, 2)) |-> !comm_active_led)
		else $error("comm_active_led high while ss_out has been high for 3 cycles");

endmodule : mitm_asserts

bind mitm_top mitm_asserts asserts_i (
	.sys_clk         (sys_clk),
	.arst_n          (arst_n),
	.sclk_in         (sclk_in),
	.ss_in           (ss_in),
	.sclk_out        (sclk_out),
	.ss_out          (ss_out),
	.comm_active_led (comm_active_led)
);

/* dv/tb_mitm_top.sv */
`timescale 1ns/1ps

module tb_mitm_top import mitm_pkg::*, spi_bus_pkg::*; ();

	localparam int DEBOUNCE = 8;
	localparam logic [CHUNK_BITS-1:0] FAKE_WORD = 9'h1A5;
	localparam int HALF = 10;	// sclk half period in sys_clk cycles
	localparam int PRESS_CYCLES = DEBOUNCE + 4;	// sync plus debounce plus margin
	localparam int N_TXN = 8;
	localparam int N_DATA = 4;	// data chunks per transaction
	localparam int WATCHDOG_NS = N_TXN * (N_DATA + 1) * 9 * 80 * 2;

	logic sys_clk;
	logic arst_n;
	logic mode_btn;
	logic miso_in;
	logic mosi_in;
	logic sclk_in;
	logic ss_in;
	logic [MODE_WIDTH-1:0] mode_leds;
	logic comm_active_led;
	logic miso_out;
	logic mosi_out;
	logic sclk_out;
	logic ss_out;

	logic [MODE_WIDTH-1:0] model_mode;	// mode the tb expects on the leds
	integer seed;
	spi_chunk_u exp_q[$];	// mosi then miso for each chunk
	spi_chunk_u obs_q[$];
	int n_checked;

	mitm_top #(
		.DEBOUNCE_COUNT (DEBOUNCE),
		.FAKE_WORD      (FAKE_WORD)
	) dut_i (
		.sys_clk         (sys_clk),
		.arst_n          (arst_n),
		.mode_btn        (mode_btn),
		.mode_leds       (mode_leds),
		.comm_active_led (comm_active_led),
		.miso_in         (miso_in),
		.mosi_in         (mosi_in),
		.sclk_in         (sclk_in),
		.ss_in           (ss_in),
		.miso_out        (miso_out),
		.mosi_out        (mosi_out),
		.sclk_out        (sclk_out),
		.ss_out          (ss_out)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;	// 4 ns period
	end

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("TESTS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input spi_chunk_u got, input spi_chunk_u exp);
		if (got.raw !== exp.raw)
			stop_run($sformatf("FAIL at %0d ns: word %0d is %03h, expected %03h",
				$time, n_checked, got.raw, exp.raw));
	endtask

	task automatic check_mode(input logic [MODE_WIDTH-1:0] got,
		input logic [MODE_WIDTH-1:0] exp);
		if (got !== exp)
			stop_run($sformatf("FAIL at %0d ns: mode_leds %03b, expected %03b",
				$time, got, exp));
	endtask

	task automatic check_level(input logic got, input logic exp, input string name);
		if (got !== exp)
			stop_run($sformatf("FAIL at %0d ns: %s is %b, expected %b",
				$time, name, got, exp));
	endtask

	// button steps forward to sub_all to sub_half and back
	function automatic logic [MODE_WIDTH-1:0] next_mode(input logic [MODE_WIDTH-1:0] m);
		case (m)
			MODE_FORWARD: return MODE_SUB_ALL;
			MODE_SUB_ALL: return MODE_SUB_HALF;
			default:      return MODE_FORWARD;
		endcase
	endfunction

	// write attacks mosi and read attacks miso
	function automatic spi_chunk_u expected_word(input logic [MODE_WIDTH-1:0] mode,
		input logic rw, input int idx, input logic is_mosi, input spi_chunk_u real_w);
		spi_chunk_u fake_w;
		logic attacked;
		logic faked;
		fake_w.raw = FAKE_WORD;
		attacked = (rw == is_mosi);
		faked = (mode == MODE_SUB_ALL) || (mode == MODE_SUB_HALF && (idx % 2) == 1);
		return (attacked && faked) ? fake_w : real_w;
	endfunction

	task automatic tick(input int n);
		repeat (n) @(posedge sys_clk);
		#1;	// inputs change just after the edge
	endtask

	task automatic press_button(input int low_cycles);
		mode_btn = 1'b0;
		tick(low_cycles);
		mode_btn = 1'b1;
		tick(DEBOUNCE + 6);	// release accepted before the next press
		if (low_cycles >= DEBOUNCE)	// low and stable for the debounce count
			model_mode = next_mode(model_mode);
		check_mode(mode_leds, model_mode);
	endtask

	// mode 0 spi master plus the slave answering with random words
	task automatic run_txn(input logic rw, input logic [7:0] addr, input int n_data);
		spi_chunk_u mosi_w;
		spi_chunk_u miso_w;
		logic [MODE_WIDTH-1:0] txn_mode;
		txn_mode = model_mode;	// dut latches at ss fall
		ss_in = 1'b0;
		for (int c = 0; c <= n_data; c++) begin
			miso_w.raw = CHUNK_BITS'($random(seed));
			if (c == 0) begin
				mosi_w.cmd.rw = rw;
				mosi_w.cmd.addr = addr;
				exp_q.push_back(mosi_w);	// command never faked
				exp_q.push_back(miso_w);
			end else begin
				mosi_w.raw = CHUNK_BITS'($random(seed));
				exp_q.push_back(expected_word(txn_mode, rw, c - 1, 1'b1, mosi_w));
				exp_q.push_back(expected_word(txn_mode, rw, c - 1, 1'b0, miso_w));
			end
			for (int b = CHUNK_BITS - 1; b >= 0; b--) begin
				mosi_in = mosi_w.raw[b];	// msb first
				miso_in = miso_w.raw[b];
				tick(HALF);
				if (c == 0 && b == CHUNK_BITS - 1)
					check_level(comm_active_led, 1'b1, "comm_active_led");	// fsm left idle
				sclk_in = 1'b1;
				tick(HALF);
				sclk_in = 1'b0;
			end
		end
		tick(HALF);
		ss_in = 1'b1;
		tick(4 * HALF);	// idle gap
	endtask

	// monitor sampling where the downstream devices would
	initial begin
		spi_chunk_u mon_mosi;
		spi_chunk_u mon_miso;
		int bit_cnt;
		bit_cnt = 0;
		forever begin
			@(posedge sclk_out);
			#1;
			mon_mosi.raw = {mon_mosi.raw[CHUNK_BITS-2:0], mosi_out};
			mon_miso.raw = {mon_miso.raw[CHUNK_BITS-2:0], miso_out};
			bit_cnt++;
			if (bit_cnt == CHUNK_BITS) begin
				obs_q.push_back(mon_mosi);
				obs_q.push_back(mon_miso);
				bit_cnt = 0;
			end
		end
	end

	// compare process
	initial begin
		n_checked = 0;
		forever begin
			@(posedge sys_clk);
			while (obs_q.size() != 0) begin
				if (exp_q.size() == 0) begin
					stop_run("a word came out of the DUT with no word expected");
				end else begin
					check_word(obs_q.pop_front(), exp_q.pop_front());
					n_checked++;
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		stop_run($sformatf("timeout: run did not finish within %0d ns", WATCHDOG_NS));
	end

	initial begin
		arst_n = 1'b0;
		mode_btn = 1'b1;
		miso_in = 1'b0;
		mosi_in = 1'b0;
		sclk_in = 1'b0;
		ss_in = 1'b1;
		seed = 32'h2795;
		model_mode = MODE_FORWARD;
		tick(3);
		arst_n = 1'b1;
		tick(2);
		check_mode(mode_leds, MODE_FORWARD);
		check_level(ss_out, 1'b1, "ss_out");
		check_level(comm_active_led, 1'b0, "comm_active_led");
		run_txn(1'b1, 8'h3C, N_DATA);	// forward both ways
		run_txn(1'b0, 8'hC3, N_DATA);
		press_button(3);	// glitch gives no step
		press_button(PRESS_CYCLES);	// sub_all
		run_txn(1'b1, 8'h11, N_DATA);
		run_txn(1'b0, 8'h22, N_DATA);
		press_button(PRESS_CYCLES);	// sub_half
		run_txn(1'b1, 8'h33, N_DATA);
		run_txn(1'b0, 8'h44, N_DATA);
		fork
			run_txn(1'b1, 8'h55, N_DATA);	// still sub_half
			begin
				tick(40);
				press_button(PRESS_CYCLES);	// third press returns to forward
			end
		join
		check_mode(mode_leds, MODE_FORWARD);
		run_txn(1'b0, 8'h66, N_DATA);
		while (exp_q.size() != 0)
			@(posedge sys_clk);
		tick(2);
		if (ss_out !== 1'b1 || comm_active_led !== 1'b0) begin
			stop_run("bus did not return to idle after the last transaction");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule : tb_mitm_top

/* run.sh */
#!/usr/bin/env bash
# build the mitm testbench with verilator, run it, judge the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_mitm_top \
	-f all.f -Mdir obj_dir -o sim_mitm &&
(./obj_dir/sim_mitm > sim.log 2>&1 || true) &&
cat sim.log &&
! grep -q "TESTS FAILED" sim.log &&
grep -q "TESTS PASSED" sim.log &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
